// File: sim.f
verilog/rv_exec_pkg.sv
verilog/rv_int_alu.sv
verilog/rv_muldiv_pipe.sv
verilog/rv_exec_ctrl.sv
verilog/rv_exec_unit.sv
verif/rv_exec_properties.sv
verif/rv_exec_unit_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the execute back end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -f sim.f --top-module rv_exec_unit_tb

out=$(./obj_dir/Vrv_exec_unit_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^PASS: all tests$"; then
    exit 0
fi
echo "simulation did not pass"
exit 1

// File: verif/rv_exec_unit_tb.sv
`timescale 1ns/1ps

module rv_exec_unit_tb import rv_exec_pkg::*; ;

    localparam int MD_STAGES   = 5;
    localparam int NUM_CYCLES  = 4000;
    localparam int STALL_LIMIT = 4 * MD_STAGES;
    localparam int DRAIN_LIMIT = 2 * MD_STAGES;

    // One expected writeback and the cycle it is due on wb_o
    typedef struct {
        wb_t  wb;
        int   due;
        logic md;
    } pend_t;

    logic   clk_i;
    logic   rst_n_i;
    logic   kill_i;
    logic   issue_valid_i;
    issue_t issue_i;
    logic   stall_o;
    wb_t    wb_o;

    integer          seed;
    int              cyc;
    int              raw_stalls;
    int              clash_stalls;
    int              kills;
    int              accepted;
    logic [ID_W-1:0] next_id;
    pend_t           exp_q [$];

    rv_exec_unit DUT (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .kill_i        (kill_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .stall_o       (stall_o),
        .wb_o          (wb_o)
    );

    bind rv_exec_ctrl rv_exec_properties u_props (
        .clk_i         (rv_exec_unit_tb.clk_i),
        .stall_i       (stall_o),
        .md_first_we_i (md_tags_i[0].rf_we),
        .alu_wb_i      (alu_wb_i),
        .md_wb_i       (md_wb_i)
    );

    always #4 clk_i = ~clk_i;

    task automatic abort_sim();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_wb(input string name, input wb_t got, input wb_t exp);
        logic bad;
        // Other fields are don't care while nothing is written
        bad = exp.rf_we ? (got !== exp) : (got.rf_we !== 1'b0);
        if (bad) begin
            $write("error at %0t ns: %s got we=%b rd=%0d data=%h id=%0d,",
                   $time, name, got.rf_we, got.rd, got.data, got.instr_id);
            $display(" expected we=%b rd=%0d data=%h id=%0d",
                     exp.rf_we, exp.rd, exp.data, exp.instr_id);
            abort_sim();
        end
    endtask

    task automatic compare_stall(input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: stall_o got %b expected %b", $time, got, exp);
            abort_sim();
        end
    endtask

    // M extension ops take the long lane
    function automatic logic uses_m_lane(input alu_op_e op);
        case (op)
            ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
            ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // RV32IM semantics, built on 64-bit arithmetic
    function automatic logic [WORD_SIZE-1:0] model_result(input alu_op_e op,
                                                          input logic [WORD_SIZE-1:0] a,
                                                          input logic [WORD_SIZE-1:0] b);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        logic [63:0]     wide;
        logic            ovf;
        sa   = longint'($signed(a));
        sb   = longint'($signed(b));
        ua   = {32'd0, a};
        ub   = {32'd0, b};
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        wide = '0;
        case (op)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a - b;
            ALU_AND:    return a & b;
            ALU_OR:     return a | b;
            ALU_XOR:    return a ^ b;
            ALU_SLL:    return a << b[4:0];
            ALU_SRL:    return a >> b[4:0];
            ALU_SRA:    wide = sa >>> b[4:0];
            ALU_SLT:    return (sa < sb) ? 32'd1 : 32'd0;
            ALU_SLTU:   return (ua < ub) ? 32'd1 : 32'd0;
            ALU_MUL:    wide = sa * sb;
            ALU_MULH:   return 32'((sa * sb) >>> 32);
            ALU_MULHSU: return 32'((sa * longint'(ub)) >>> 32);
            ALU_MULHU:  return 32'((ua * ub) >> 32);
            ALU_DIV: begin
                if (b == '0) begin
                    return '1;
                end else if (ovf) begin
                    return a;
                end
                wide = sa / sb;
            end
            ALU_DIVU: begin
                if (b == '0) begin
                    return '1;
                end
                wide = ua / ub;
            end
            ALU_REM: begin
                if (b == '0) begin
                    return a;
                end else if (ovf) begin
                    return '0;
                end
                wide = sa % sb;
            end
            ALU_REMU: begin
                if (b == '0) begin
                    return a;
                end
                wide = ua % ub;
            end
            default:    wide = '0;
        endcase
        return wide[31:0];
    endfunction

    // Small pool so that sources often hit in-flight destinations
    function automatic logic [REG_SIZE-1:0] rand_reg();
        int unsigned pick;
        pick = {$random(seed)} % 5;
        return (pick == 4) ? 5'd31 : pick[4:0];
    endfunction

    function automatic logic [WORD_SIZE-1:0] rand_operand();
        int unsigned pick;
        pick = {$random(seed)} % 8;
        case (pick)
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return 32'd1;
            default: return $random(seed);
        endcase
    endfunction

    function automatic alu_op_e rand_op();
        int unsigned pick;
        pick = {$random(seed)} % 18;
        if (pick < 10) begin
            return alu_op_e'(pick[4:0]);
        end
        return alu_op_e'(pick[4:0] + 5'd6);
    endfunction

    function automatic issue_t new_issue(input logic [ID_W-1:0] id);
        issue_t ins;
        ins.op       = rand_op();
        ins.src_a    = rand_operand();
        ins.src_b    = rand_operand();
        ins.rs1      = rand_reg();
        ins.rs2      = rand_reg();
        ins.rd       = rand_reg();
        ins.rf_we    = ({$random(seed)} % 8) != 0;
        ins.instr_id = id;
        return ins;
    endfunction

    // Check this cycle against the model, then advance it one clock
    task automatic step_model(output logic stall_exp);
        logic  raw;
        logic  clash;
        logic  md;
        wb_t   exp_wb;
        pend_t ent;
        raw   = 1'b0;
        clash = 1'b0;
        md    = uses_m_lane(issue_i.op);
        foreach (exp_q[i]) begin
            if (exp_q[i].md) begin
                if ((issue_i.rs1 != '0) && (issue_i.rs1 == exp_q[i].wb.rd)) begin
                    raw = 1'b1;
                end
                if ((issue_i.rs2 != '0) && (issue_i.rs2 == exp_q[i].wb.rd)) begin
                    raw = 1'b1;
                end
                if (!md && (exp_q[i].due == cyc + 1)) begin
                    clash = 1'b1;
                end
            end
        end
        stall_exp = issue_valid_i && (raw || clash);
        compare_stall(stall_o, stall_exp);

        exp_wb = '0;
        foreach (exp_q[i]) begin
            if (exp_q[i].due == cyc) begin
                exp_wb = exp_q[i].wb;
            end
        end
        if (kill_i) begin
            exp_wb.rf_we = 1'b0;
        end
        compare_wb("wb_o", wb_o, exp_wb);

        for (int i = exp_q.size() - 1; i >= 0; i--) begin
            if (exp_q[i].due <= cyc) begin
                exp_q.delete(i);
            end
        end
        if (issue_valid_i && raw) begin
            raw_stalls++;
        end
        if (issue_valid_i && clash) begin
            clash_stalls++;
        end
        if (kill_i) begin
            exp_q.delete();
            kills++;
        end else if (issue_valid_i && !stall_exp) begin
            accepted++;
            if (issue_i.rf_we) begin
                ent.wb.rf_we    = 1'b1;
                ent.wb.rd       = issue_i.rd;
                ent.wb.data     = model_result(issue_i.op, issue_i.src_a, issue_i.src_b);
                ent.wb.instr_id = issue_i.instr_id;
                ent.due         = cyc + (md ? MD_STAGES : 1);
                ent.md          = md;
                exp_q.push_back(ent);
            end
        end
        cyc++;
    endtask

    initial begin
        logic stalled;
        logic hold;
        int   hold_cycles;
        int   drain_cycles;
        seed          = 32'h9f5d_cedb;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        kill_i        = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        cyc           = 0;
        raw_stalls    = 0;
        clash_stalls  = 0;
        kills         = 0;
        accepted      = 0;
        next_id       = '0;
        hold          = 1'b0;
        hold_cycles   = 0;

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i       = 1'b1;
        // First offer meets an empty back end and must go straight in
        issue_valid_i = 1'b1;
        issue_i       = new_issue(next_id);
        next_id++;
        #1;
        step_model(stalled);

        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(negedge clk_i);
            if (!hold) begin
                issue_valid_i = ({$random(seed)} % 5) != 0;
                issue_i       = new_issue(next_id);
                next_id++;
            end
            kill_i = ({$random(seed)} % 40) == 0;
            #1;
            step_model(stalled);
            // A stalled op is held and offered again
            hold = issue_valid_i && stalled && !kill_i;
            hold_cycles = hold ? hold_cycles + 1 : 0;
            if (hold_cycles > STALL_LIMIT) begin
                $display("instruction %0d stayed stalled for more than %0d cycles",
                         issue_i.instr_id, STALL_LIMIT);
                abort_sim();
            end
        end

        drain_cycles = 0;
        while (exp_q.size() != 0) begin
            if (drain_cycles > DRAIN_LIMIT) begin
                $display("results still pending %0d cycles after the last issue", DRAIN_LIMIT);
                abort_sim();
            end
            @(negedge clk_i);
            issue_valid_i = 1'b0;
            kill_i        = 1'b0;
            #1;
            step_model(stalled);
            drain_cycles++;
        end

        $display("accepted %0d, raw stalls %0d, collision stalls %0d, kills %0d",
                 accepted, raw_stalls, clash_stalls, kills);
        if ((raw_stalls == 0) || (clash_stalls == 0) || (kills == 0)) begin
            $display("random stimulus missed a RAW stall, a collision stall or a kill");
            abort_sim();
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule : rv_exec_unit_tb

// File: verif/rv_exec_properties.sv
`timescale 1ns/1ps

module rv_exec_properties import rv_exec_pkg::*; (
    input logic clk_i,
    input logic stall_i,
    input logic md_first_we_i,
    input wb_t  alu_wb_i,
    input wb_t  md_wb_i
);

    // One op per edge, so the integer lane and M stage 1 never load together
    one_lane_per_edge: assert property (
        @(posedge clk_i) !(alu_wb_i.rf_we && md_first_we_i)
    ) else $error("integer lane and M stage 1 loaded at the same edge");

    // A stalled offer leaves both lane inputs empty at the next edge
    stall_loads_nothing: assert property (
        @(posedge clk_i) stall_i |=> !(alu_wb_i.rf_we || md_first_we_i)
    ) else $error("lane loaded although the offered op was stalled");

    // Collision stall keeps the lanes apart at writeback
    wb_no_collision: assert property (
        @(posedge clk_i) !(alu_wb_i.rf_we && md_wb_i.rf_we)
    ) else $error("both lanes write back in the same cycle");

endmodule : rv_exec_properties

// File: verilog/rv_exec_unit.sv
`timescale 1ns/1ps

module rv_exec_unit import rv_exec_pkg::*; #(
    parameter int MD_STAGES = 5
) (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   kill_i,
    input  logic   issue_valid_i,
    input  issue_t issue_i,
    output logic   stall_o,
    output wb_t    wb_o
);

    logic    alu_go;
    logic    md_go;
    wb_t     alu_wb;
    wb_t     md_wb;
    md_tag_t md_tags [MD_STAGES];

    // Single-cycle RV32I lane
    rv_int_alu u_int_alu (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .kill_i  (kill_i),
        .go_i    (alu_go),
        .issue_i (issue_i),
        .wb_o    (alu_wb)
    );

    // Multiply and divide lane
    rv_muldiv_pipe #(
        .MD_STAGES (MD_STAGES)
    ) u_muldiv_pipe (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .kill_i  (kill_i),
        .go_i    (md_go),
        .issue_i (issue_i),
        .wb_o    (md_wb),
        .tags_o  (md_tags)
    );

    // Hazards, steering and writeback merge
    rv_exec_ctrl #(
        .MD_STAGES (MD_STAGES)
    ) u_exec_ctrl (
        .issue_valid_i (issue_valid_i),
        .kill_i        (kill_i),
        .issue_i       (issue_i),
        .md_tags_i     (md_tags),
        .alu_wb_i      (alu_wb),
        .md_wb_i       (md_wb),
        .stall_o       (stall_o),
        .alu_go_o      (alu_go),
        .md_go_o       (md_go),
        .wb_o          (wb_o)
    );

endmodule : rv_exec_unit

// File: verilog/rv_exec_ctrl.sv
`timescale 1ns/1ps

module rv_exec_ctrl import rv_exec_pkg::*; #(
    parameter int MD_STAGES = 5
) (
    input  logic    issue_valid_i,
    input  logic    kill_i,
    input  issue_t  issue_i,
    input  md_tag_t md_tags_i [MD_STAGES],
    input  wb_t     alu_wb_i,
    input  wb_t     md_wb_i,
    output logic    stall_o,
    output logic    alu_go_o,
    output logic    md_go_o,
    output wb_t     wb_o
);

    logic is_md;
    logic raw_hit;
    logic wb_clash;
    logic accept;
    wb_t  wb_sel;

    assign is_md = is_muldiv(issue_i.op);

    // Sources against every in-flight M destination, x0 excluded
    always_comb begin
        raw_hit = 1'b0;
        for (int k = 0; k < MD_STAGES; k++) begin
            if (md_tags_i[k].rf_we) begin
                if ((issue_i.rs1 != '0) && (issue_i.rs1 == md_tags_i[k].rd)) begin
                    raw_hit = 1'b1;
                end
                if ((issue_i.rs2 != '0) && (issue_i.rs2 == md_tags_i[k].rd)) begin
                    raw_hit = 1'b1;
                end
            end
        end
    end

    // Stage MD_STAGES-1 writes back next cycle, same as an integer op taken now
    assign wb_clash = ~is_md & md_tags_i[MD_STAGES-2].rf_we;

    assign stall_o  = issue_valid_i & (raw_hit | wb_clash);
    assign accept   = issue_valid_i & ~stall_o & ~kill_i;
    assign alu_go_o = accept & ~is_md;
    assign md_go_o  = accept & is_md;

    // Both lanes never write back together, so M lane simply wins
    always_comb begin
        if (md_wb_i.rf_we) begin
            wb_sel = md_wb_i;
        end else begin
            wb_sel = alu_wb_i;
        end
    end

    assign wb_o.rf_we    = wb_sel.rf_we & ~kill_i;
    assign wb_o.rd       = wb_sel.rd;
    assign wb_o.data     = wb_sel.data;
    assign wb_o.instr_id = wb_sel.instr_id;

endmodule : rv_exec_ctrl

// File: verilog/rv_muldiv_pipe.sv
`timescale 1ns/1ps

module rv_muldiv_pipe import rv_exec_pkg::*; #(
    parameter int MD_STAGES = 5
) (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    kill_i,
    input  logic    go_i,
    input  issue_t  issue_i,
    output wb_t     wb_o,
    output md_tag_t tags_o [MD_STAGES]
);

    typedef struct packed {
        logic [WORD_SIZE-1:0] data;
        logic [REG_SIZE-1:0]  rd;
        logic [ID_W-1:0]      instr_id;
    } md_data_t;

    localparam logic [WORD_SIZE-1:0] MOST_NEG = {1'b1, {(WORD_SIZE-1){1'b0}}};

    logic [WORD_SIZE-1:0]   src_a;
    logic [WORD_SIZE-1:0]   src_b;
    logic [2*WORD_SIZE-1:0] prod_ss;
    logic [2*WORD_SIZE-1:0] prod_uu;
    logic [2*WORD_SIZE-1:0] prod_su;
    logic                   div_zero;
    logic                   div_ovf;
    logic [WORD_SIZE-1:0]   result;

    // Stage k+1 lives at index k
    logic [MD_STAGES-1:0]   we_q;
    md_data_t               data_q [MD_STAGES];

    assign src_a = issue_i.src_a;
    assign src_b = issue_i.src_b;

    always_comb begin
        prod_ss = $signed(src_a) * $signed(src_b);
        prod_uu = src_a * src_b;
        // Mixed product, sign of a only; low 64 bits are exact mod 2^64
        prod_su = {{WORD_SIZE{src_a[WORD_SIZE-1]}}, src_a} * {{WORD_SIZE{1'b0}}, src_b};
    end

    assign div_zero = (src_b == '0);
    assign div_ovf  = (src_a == MOST_NEG) && (src_b == '1);

    always_comb begin
        unique case (issue_i.op)
            ALU_MUL:    result = prod_ss[WORD_SIZE-1:0];
            ALU_MULH:   result = prod_ss[2*WORD_SIZE-1:WORD_SIZE];
            ALU_MULHSU: result = prod_su[2*WORD_SIZE-1:WORD_SIZE];
            ALU_MULHU:  result = prod_uu[2*WORD_SIZE-1:WORD_SIZE];
            ALU_DIV: begin
                if (div_zero) begin
                    result = '1;
                end else if (div_ovf) begin
                    result = src_a;
                end else begin
                    result = $unsigned($signed(src_a) / $signed(src_b));
                end
            end
            ALU_DIVU: begin
                if (div_zero) begin
                    result = '1;
                end else begin
                    result = src_a / src_b;
                end
            end
            ALU_REM: begin
                if (div_zero) begin
                    result = src_a;
                end else if (div_ovf) begin
                    result = '0;
                end else begin
                    result = $unsigned($signed(src_a) % $signed(src_b));
                end
            end
            ALU_REMU: begin
                if (div_zero) begin
                    result = src_a;
                end else begin
                    result = src_a % src_b;
                end
            end
            // Integer ops never reach this lane
            default: result = '0;
        endcase
    end

    // Write enables shift with the data, kill drops them all
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            we_q <= '0;
        end else if (kill_i) begin
            we_q <= '0;
        end else begin
            we_q <= {we_q[MD_STAGES-2:0], go_i & issue_i.rf_we};
        end
    end

    always_ff @(posedge clk_i) begin
        data_q[0].data     <= result;
        data_q[0].rd       <= issue_i.rd;
        data_q[0].instr_id <= issue_i.instr_id;
        for (int k = 1; k < MD_STAGES; k++) begin
            data_q[k] <= data_q[k-1];
        end
    end

    always_comb begin
        for (int k = 0; k < MD_STAGES; k++) begin
            tags_o[k].rf_we = we_q[k];
            tags_o[k].rd    = data_q[k].rd;
        end
    end

    assign wb_o.rf_we    = we_q[MD_STAGES-1];
    assign wb_o.rd       = data_q[MD_STAGES-1].rd;
    assign wb_o.data     = data_q[MD_STAGES-1].data;
    assign wb_o.instr_id = data_q[MD_STAGES-1].instr_id;

endmodule : rv_muldiv_pipe

// File: verilog/rv_int_alu.sv
`timescale 1ns/1ps

module rv_int_alu import rv_exec_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   kill_i,
    input  logic   go_i,
    input  issue_t issue_i,
    output wb_t    wb_o
);

    localparam int SHAMT_W = $clog2(WORD_SIZE);

    typedef struct packed {
        logic [WORD_SIZE-1:0] data;
        logic [REG_SIZE-1:0]  rd;
        logic [ID_W-1:0]      instr_id;
    } alu_data_t;

    logic [WORD_SIZE-1:0] src_a;
    logic [WORD_SIZE-1:0] src_b;
    logic [SHAMT_W-1:0]   shamt;
    logic [WORD_SIZE-1:0] result;
    logic                 rf_we_q;
    alu_data_t            data_q;

    assign src_a = issue_i.src_a;
    assign src_b = issue_i.src_b;
    assign shamt = src_b[SHAMT_W-1:0];

    always_comb begin
        unique case (issue_i.op)
            ALU_ADD:  result = src_a + src_b;
            ALU_SUB:  result = src_a - src_b;
            ALU_AND:  result = src_a & src_b;
            ALU_OR:   result = src_a | src_b;
            ALU_XOR:  result = src_a ^ src_b;
            ALU_SLL:  result = src_a << shamt;
            ALU_SRL:  result = src_a >> shamt;
            ALU_SRA:  result = $unsigned($signed(src_a) >>> shamt);
            ALU_SLT:  result = {{(WORD_SIZE-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_SLTU: result = {{(WORD_SIZE-1){1'b0}}, src_a < src_b};
            // M ops never reach this lane
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rf_we_q <= 1'b0;
        end else begin
            rf_we_q <= go_i & issue_i.rf_we & ~kill_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (go_i) begin
            data_q.data     <= result;
            data_q.rd       <= issue_i.rd;
            data_q.instr_id <= issue_i.instr_id;
        end
    end

    assign wb_o.rf_we    = rf_we_q;
    assign wb_o.rd       = data_q.rd;
    assign wb_o.data     = data_q.data;
    assign wb_o.instr_id = data_q.instr_id;

endmodule : rv_int_alu

// File: verilog/rv_exec_pkg.sv
package rv_exec_pkg;

    localparam int WORD_SIZE = 32;
    localparam int REG_SIZE  = 5;
    localparam int ID_W      = 4;

    // Bit 4 set marks the M extension ops
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_AND    = 5'd2,
        ALU_OR     = 5'd3,
        ALU_XOR    = 5'd4,
        ALU_SLL    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_SLT    = 5'd8,
        ALU_SLTU   = 5'd9,
        ALU_MUL    = 5'd16,
        ALU_MULH   = 5'd17,
        ALU_MULHSU = 5'd18,
        ALU_MULHU  = 5'd19,
        ALU_DIV    = 5'd20,
        ALU_DIVU   = 5'd21,
        ALU_REM    = 5'd22,
        ALU_REMU   = 5'd23
    } alu_op_e;

    // Instruction as offered by the issuer, operands already read
    typedef struct packed {
        alu_op_e               op;
        logic [WORD_SIZE-1:0]  src_a;
        logic [WORD_SIZE-1:0]  src_b;
        logic [REG_SIZE-1:0]   rs1;
        logic [REG_SIZE-1:0]   rs2;
        logic [REG_SIZE-1:0]   rd;
        logic                  rf_we;
        logic [ID_W-1:0]       instr_id;
    } issue_t;

    typedef struct packed {
        logic                  rf_we;
        logic [REG_SIZE-1:0]   rd;
        logic [WORD_SIZE-1:0]  data;
        logic [ID_W-1:0]       instr_id;
    } wb_t;

    // Destination still in flight in the M lane
    typedef struct packed {
        logic                  rf_we;
        logic [REG_SIZE-1:0]   rd;
    } md_tag_t;

    function automatic logic is_muldiv(input alu_op_e op);
        logic res;
        res = op inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
                         ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
        return res;
    endfunction

endpackage : rv_exec_pkg
